/* design/frontEndPkg.sv */
// Front end package
// Opcodes, table sizes and the payload structs that move through the fetch pipeline

`default_nettype none

package frontEndPkg;

    // Data and address width
    localparam int xlenBits = 32;

    localparam logic [xlenBits-1:0] pcStart = 32'h0000_0000;

    // RV32I opcodes and function codes kept by this front end
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;

    localparam logic [2:0] funct3Beq = 3'b000;
    localparam logic [2:0] funct3Bne = 3'b001;

    // BTB geometry, index is PC[6:2] and tag is PC[31:7]
    localparam int btbEntries = 32;
    localparam int btbIdxBits = 5;
    localparam int btbTagBits = 25;

    // History length, also the PHT index width
    localparam int ghrBits = 5;

    // Weakly not taken
    localparam logic [1:0] counterInit = 2'b01;

    typedef logic [xlenBits-1:0] addr_t;

    // Prediction made in fetch, carried down to execute
    typedef struct packed {
        logic               taken;
        logic [ghrBits-1:0] phtIdx;
    } predMeta_t;

    typedef struct packed {
        logic [31:0] instr;
        addr_t       pc;
        predMeta_t   meta;
    } decodePayload_t;

    typedef struct packed {
        logic [6:0] op;
        logic [2:0] funct3;
        addr_t      pc;
        addr_t      imm;
        predMeta_t  meta;
    } executePayload_t;

    // Outcome of the branch or jal sitting in execute
    typedef struct packed {
        logic               valid;
        logic               isBranch;
        logic               taken;
        addr_t              pc;
        addr_t              target;
        logic [ghrBits-1:0] phtIdx;
    } resolveInfo_t;

endpackage

`default_nettype wire

/* design/pcGenerator.sv */
// Fetch PC register
// Picks the redirect, the predicted target or the sequential PC on each enabled edge

`timescale 1ns/1ps
`default_nettype none

module pcGenerator (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  enable_i,
    input  wire                  redirect_i,
    input  wire frontEndPkg::addr_t redirectPc_i,
    input  wire                  predTaken_i,
    input  wire frontEndPkg::addr_t predTarget_i,
    output frontEndPkg::addr_t   pcF_o
);

    frontEndPkg::addr_t pcNext;
    frontEndPkg::addr_t pcPlus4;

    assign pcPlus4 = pcF_o + frontEndPkg::addr_t'(4);

    // Redirect from execute wins over the fetch prediction
    always_comb begin
        if (redirect_i) begin
            pcNext = redirectPc_i;
        end else if (predTaken_i) begin
            pcNext = predTarget_i;
        end else begin
            pcNext = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF_o <= frontEndPkg::pcStart;
        end else if (enable_i) begin
            pcF_o <= pcNext;
        end
    end

endmodule

`default_nettype wire

/* design/branchTargetBuffer.sv */
// Branch target buffer
// Direct-mapped, tagged; looked up in fetch and filled by taken resolutions

`timescale 1ns/1ps
`default_nettype none

module branchTargetBuffer (
    input  wire                          clk,
    input  wire                          reset,
    input  wire frontEndPkg::addr_t         pcF_i,
    output logic                         hit_o,
    output frontEndPkg::addr_t           target_o,
    input  wire frontEndPkg::resolveInfo_t  resolve_i
);

    localparam int idxHi = frontEndPkg::btbIdxBits + 1;
    localparam int tagLo = frontEndPkg::btbIdxBits + 2;

    logic [frontEndPkg::btbEntries-1:0] validBits;
    logic [frontEndPkg::btbTagBits-1:0] tagMem [frontEndPkg::btbEntries];
    frontEndPkg::addr_t                 targetMem [frontEndPkg::btbEntries];

    logic [frontEndPkg::btbIdxBits-1:0] rdIdx;
    logic [frontEndPkg::btbIdxBits-1:0] wrIdx;
    logic                               wrEn;

    // Lookup
    assign rdIdx    = pcF_i[idxHi:2];
    assign hit_o    = validBits[rdIdx] && (tagMem[rdIdx] == pcF_i[frontEndPkg::xlenBits-1:tagLo]);
    assign target_o = targetMem[rdIdx];

    // Taken branches and every jal allocate
    assign wrIdx = resolve_i.pc[idxHi:2];
    assign wrEn  = resolve_i.valid && resolve_i.taken;

    always_ff @(posedge clk) begin
        if (reset) begin
            validBits <= '0;
        end else if (wrEn) begin
            validBits[wrIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            tagMem[wrIdx]    <= resolve_i.pc[frontEndPkg::xlenBits-1:tagLo];
            targetMem[wrIdx] <= resolve_i.target;
        end
    end

endmodule

`default_nettype wire

/* design/gsharePredictor.sv */
// Gshare direction predictor
// Global history XOR PC indexes a table of two-bit counters

`timescale 1ns/1ps
`default_nettype none

module gsharePredictor (
    input  wire                          clk,
    input  wire                          reset,
    input  wire frontEndPkg::addr_t         pcF_i,
    input  wire [6:0]                    opF_i,
    input  wire                          fetchAdvance_i,
    input  wire                          btbHit_i,
    input  wire                          mispredict_i,
    input  wire frontEndPkg::resolveInfo_t  resolve_i,
    output frontEndPkg::predMeta_t       meta_o
);

    localparam int histBits   = frontEndPkg::ghrBits;
    localparam int phtEntries = 2 ** histBits;

    logic [histBits-1:0] ghr;
    logic [1:0]          pht [phtEntries];

    logic [histBits-1:0] idx;
    logic                isBranchF;
    logic                isJalF;
    logic                predTaken;

    assign isBranchF = (opF_i == frontEndPkg::opBranch);
    assign isJalF    = (opF_i == frontEndPkg::opJal);

    assign idx = ghr ^ pcF_i[histBits+1:2];

    // Nothing is taken without a target, jal needs only the hit
    assign predTaken = btbHit_i && (isJalF || (isBranchF && pht[idx][1]));

    assign meta_o.taken  = predTaken;
    assign meta_o.phtIdx = idx;

    // History register
    always_ff @(posedge clk) begin
        if (reset || mispredict_i) begin
            ghr <= '0;
        end else if (fetchAdvance_i && isBranchF) begin
            ghr <= {ghr[histBits-2:0], predTaken};
        end
    end

    // Saturating counters, trained by resolved branches only
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < phtEntries; i++) begin
                pht[i] <= frontEndPkg::counterInit;
            end
        end else if (resolve_i.valid && resolve_i.isBranch) begin
            if (resolve_i.taken) begin
                if (pht[resolve_i.phtIdx] != 2'b11) begin
                    pht[resolve_i.phtIdx] <= pht[resolve_i.phtIdx] + 2'b01;
                end
            end else if (pht[resolve_i.phtIdx] != 2'b00) begin
                pht[resolve_i.phtIdx] <= pht[resolve_i.phtIdx] - 2'b01;
            end
        end
    end

endmodule

`default_nettype wire

/* design/pipeStage.sv */
// Pipeline register
// Loads a bubble on reset or flush and holds its payload while disabled

`timescale 1ns/1ps
`default_nettype none

module pipeStage #(
    parameter type payload_t = logic
) (
    input  wire           clk,
    input  wire           reset,
    input  wire           enable_i,
    input  wire           flush_i,
    input  wire payload_t d_i,
    output payload_t      q_o
);

    // An all-zero payload decodes as no branch and no jal
    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            q_o <= '0;
        end else if (enable_i) begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

/* design/branchResolver.sv */
// Branch resolver
// Works out the real direction and target in execute and flags a mispredict

`timescale 1ns/1ps
`default_nettype none

module branchResolver (
    input  wire frontEndPkg::executePayload_t exec_i,
    input  wire frontEndPkg::addr_t           rs1Val_i,
    input  wire frontEndPkg::addr_t           rs2Val_i,
    output frontEndPkg::resolveInfo_t      resolve_o,
    output logic                           mispredict_o,
    output frontEndPkg::addr_t             redirectPc_o
);

    logic               isBranch;
    logic               isJal;
    logic               operandsEqual;
    logic               branchTaken;
    logic               actualTaken;
    frontEndPkg::addr_t target;
    frontEndPkg::addr_t pcPlus4;

    assign isBranch = (exec_i.op == frontEndPkg::opBranch);
    assign isJal    = (exec_i.op == frontEndPkg::opJal);

    // Equality compare stands in for the ALU zero flag
    assign operandsEqual = (rs1Val_i == rs2Val_i);

    always_comb begin
        case (exec_i.funct3)
            frontEndPkg::funct3Beq: branchTaken = operandsEqual;
            frontEndPkg::funct3Bne: branchTaken = !operandsEqual;
            default:                branchTaken = 1'b0;
        endcase
    end

    assign actualTaken = isJal || (isBranch && branchTaken);

    assign target  = exec_i.pc + exec_i.imm;
    assign pcPlus4 = exec_i.pc + frontEndPkg::addr_t'(4);

    assign resolve_o.valid    = isBranch || isJal;
    assign resolve_o.isBranch = isBranch;
    assign resolve_o.taken    = actualTaken;
    assign resolve_o.pc       = exec_i.pc;
    assign resolve_o.target   = target;
    assign resolve_o.phtIdx   = exec_i.meta.phtIdx;

    // Bubbles carry a not-taken prediction, so they never mispredict
    assign mispredict_o = resolve_o.valid && (actualTaken != exec_i.meta.taken);

    // Where fetch should have gone
    assign redirectPc_o = actualTaken ? target : pcPlus4;

endmodule

`default_nettype wire

/* design/frontControl.sv */
// Front end control
// Stall and flush priority for the PC, decode and execute registers

`timescale 1ns/1ps
`default_nettype none

module frontControl (
    input  wire  clk,
    input  wire  reset,
    input  wire  stallF_i,
    input  wire  mispredict_i,
    output logic pcEnable_o,
    output logic fetchAdvance_o,
    output logic decodeEnable_o,
    output logic decodeFlush_o,
    output logic executeFlush_o
);

    // High in the cycle after a mispredict, when fetch sits on the redirect PC
    logic redirectLanded;

    always_ff @(posedge clk) begin
        if (reset) begin
            redirectLanded <= 1'b0;
        end else begin
            redirectLanded <= mispredict_i;
        end
    end

    // Mispredict overrides the stall
    assign pcEnable_o = mispredict_i || !stallF_i;

    assign decodeEnable_o = !stallF_i;
    assign decodeFlush_o  = mispredict_i;

    // A stalled decode leaves a bubble behind it in execute
    assign executeFlush_o = mispredict_i || stallF_i;

    // History only moves for an unstalled fetch outside the landing cycle
    assign fetchAdvance_o = !stallF_i && !redirectLanded;

endmodule

`default_nettype wire

/* design/fetchFrontEnd.sv */
// Fetch front end top
// PC generation, BTB and gshare prediction, decode and execute registers and resolution

`timescale 1ns/1ps
`default_nettype none

module fetchFrontEnd (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       stallF_i,
    input  wire [31:0]                instrF_i,
    input  wire frontEndPkg::addr_t      rs1ValE_i,
    input  wire frontEndPkg::addr_t      rs2ValE_i,
    output frontEndPkg::addr_t        pcF_o,
    output logic                      mispredict_o,
    output frontEndPkg::addr_t        redirectPc_o,
    output frontEndPkg::resolveInfo_t resolve_o
);

    logic pcEnable;
    logic fetchAdvance;
    logic decodeEnable;
    logic decodeFlush;
    logic executeFlush;

    logic                  btbHit;
    frontEndPkg::addr_t    btbTarget;
    frontEndPkg::predMeta_t metaF;

    frontEndPkg::decodePayload_t  decodeD;
    frontEndPkg::decodePayload_t  decodeQ;
    frontEndPkg::executePayload_t executeD;
    frontEndPkg::executePayload_t executeQ;

    logic [31:0]        instrD;
    frontEndPkg::addr_t immD;

    frontControl frontControl_inst (
        .clk           (clk),
        .reset         (reset),
        .stallF_i      (stallF_i),
        .mispredict_i  (mispredict_o),
        .pcEnable_o    (pcEnable),
        .fetchAdvance_o(fetchAdvance),
        .decodeEnable_o(decodeEnable),
        .decodeFlush_o (decodeFlush),
        .executeFlush_o(executeFlush)
    );

    pcGenerator pcGenerator_inst (
        .clk         (clk),
        .reset       (reset),
        .enable_i    (pcEnable),
        .redirect_i  (mispredict_o),
        .redirectPc_i(redirectPc_o),
        .predTaken_i (metaF.taken),
        .predTarget_i(btbTarget),
        .pcF_o       (pcF_o)
    );

    branchTargetBuffer branchTargetBuffer_inst (
        .clk      (clk),
        .reset    (reset),
        .pcF_i    (pcF_o),
        .hit_o    (btbHit),
        .target_o (btbTarget),
        .resolve_i(resolve_o)
    );

    gsharePredictor gsharePredictor_inst (
        .clk           (clk),
        .reset         (reset),
        .pcF_i         (pcF_o),
        .opF_i         (instrF_i[6:0]),
        .fetchAdvance_i(fetchAdvance),
        .btbHit_i      (btbHit),
        .mispredict_i  (mispredict_o),
        .resolve_i     (resolve_o),
        .meta_o        (metaF)
    );

    // Fetch to decode
    assign decodeD.instr = instrF_i;
    assign decodeD.pc    = pcF_o;
    assign decodeD.meta  = metaF;

    pipeStage #(.payload_t(frontEndPkg::decodePayload_t)) decodeReg (
        .clk     (clk),
        .reset   (reset),
        .enable_i(decodeEnable),
        .flush_i (decodeFlush),
        .d_i     (decodeD),
        .q_o     (decodeQ)
    );

    // Immediate extraction, only B and J forms matter here
    assign instrD = decodeQ.instr;

    always_comb begin
        case (instrD[6:0])
            frontEndPkg::opBranch:
                immD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
            frontEndPkg::opJal:
                immD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
            default:
                immD = '0;
        endcase
    end

    assign executeD.op     = instrD[6:0];
    assign executeD.funct3 = instrD[14:12];
    assign executeD.pc     = decodeQ.pc;
    assign executeD.imm    = immD;
    assign executeD.meta   = decodeQ.meta;

    // Execute never holds, a stall turns into a bubble through the flush
    pipeStage #(.payload_t(frontEndPkg::executePayload_t)) executeReg (
        .clk     (clk),
        .reset   (reset),
        .enable_i(1'b1),
        .flush_i (executeFlush),
        .d_i     (executeD),
        .q_o     (executeQ)
    );

    branchResolver branchResolver_inst (
        .exec_i      (executeQ),
        .rs1Val_i    (rs1ValE_i),
        .rs2Val_i    (rs2ValE_i),
        .resolve_o   (resolve_o),
        .mispredict_o(mispredict_o),
        .redirectPc_o(redirectPc_o)
    );

endmodule

`default_nettype wire

/* verif/clockGen.sv */
// Testbench clock and reset source
// Free-running clock, reset held high for a fixed number of cycles

`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int halfPeriod  = 4,
    parameter int resetCycles = 10
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(halfPeriod) clk_o = ~clk_o;
    end

    // Release on a falling edge, away from the DUT sampling edge
    initial begin
        reset_o = 1'b1;
        repeat (resetCycles) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

`default_nettype wire

/* verif/fetchFrontEndTb.sv */
// Testbench for the fetch front end
// Runs a small branch loop against a reference BTB, gshare and pipeline model

`timescale 1ns/1ps
`default_nettype none

module fetchFrontEndTb;

    localparam int clkPeriod   = 8;
    localparam int runCycles   = 1800;
    localparam int flipCycle   = 900;
    localparam int limitCycles = runCycles + 200;
    localparam int phtSize     = 2 ** frontEndPkg::ghrBits;

    // Instruction kinds in the program
    localparam logic [1:0] kOther = 2'd0;
    localparam logic [1:0] kBeq   = 2'd1;
    localparam logic [1:0] kBne   = 2'd2;
    localparam logic [1:0] kJal   = 2'd3;

    // One instruction in flight in the reference pipeline
    typedef struct packed {
        logic [1:0]                      kind;
        frontEndPkg::addr_t              pc;
        logic [31:0]                     offset;
        logic                            predTaken;
        logic [frontEndPkg::ghrBits-1:0] phtIdx;
    } slot_t;

    logic                      clk;
    logic                      reset;
    logic                      stallF;
    logic [31:0]               instrF;
    frontEndPkg::addr_t        rs1ValE;
    frontEndPkg::addr_t        rs2ValE;
    frontEndPkg::addr_t        pcF;
    logic                      mispredict;
    frontEndPkg::addr_t        redirectPc;
    frontEndPkg::resolveInfo_t resolve;

    // Program memory with side tables for the reference model
    logic [31:0] imem [64];
    logic [1:0]  kindMem [64];
    logic [31:0] offsetMem [64];

    frontEndPkg::addr_t              refPc;
    slot_t                           decSlot;
    slot_t                           exeSlot;
    logic [frontEndPkg::ghrBits-1:0] refGhr;
    logic [1:0]                      refPht [phtSize];
    logic                            btbValid [32];
    logic [24:0]                     btbTag [32];
    frontEndPkg::addr_t              btbTarget [32];
    logic                            landed;

    integer seed;
    int     cycle;
    int     mispredicts;
    int     jalHits;
    int     fallThroughs;
    int     stalls;

    clockGen #(.halfPeriod(clkPeriod / 2), .resetCycles(10)) clockGen_inst (
        .clk_o  (clk),
        .reset_o(reset)
    );

    fetchFrontEnd fetchFrontEnd_inst (
        .clk         (clk),
        .reset       (reset),
        .stallF_i    (stallF),
        .instrF_i    (instrF),
        .rs1ValE_i   (rs1ValE),
        .rs2ValE_i   (rs2ValE),
        .pcF_o       (pcF),
        .mispredict_o(mispredict),
        .redirectPc_o(redirectPc),
        .resolve_o   (resolve)
    );

    task automatic stopWithFailure();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stopWithFailure();
        end
    endtask

    // Assembles B and J words, other slots get an addi tagged with its address
    function automatic logic [31:0] encodeWord(input logic [1:0] kind, input logic [31:0] off,
                                               input int idx);
        logic [5:0] wordIdx;
        wordIdx = idx[5:0];
        case (kind)
            kBeq: return {off[12], off[10:5], 5'd2, 5'd1, frontEndPkg::funct3Beq,
                          off[4:1], off[11], frontEndPkg::opBranch};
            kBne: return {off[12], off[10:5], 5'd2, 5'd1, frontEndPkg::funct3Bne,
                          off[4:1], off[11], frontEndPkg::opBranch};
            kJal: return {off[20], off[10:1], off[11], off[19:12], 5'd0, frontEndPkg::opJal};
            default: return {4'b0000, wordIdx, 2'b00, 13'd0, 7'b0010011};
        endcase
    endfunction

    task automatic placeInstr(input int idx, input logic [1:0] kind, input int off);
        kindMem[idx]   = kind;
        offsetMem[idx] = off;
        imem[idx]      = encodeWord(kind, off, idx);
    endtask

    // Operands follow the reference execute slot
    task automatic driveInputs();
        logic equalOps;
        stallF  = ($random(seed) & 3) == 0;
        instrF  = imem[pcF[7:2]];
        rs1ValE = $random(seed);
        case (exeSlot.kind)
            kBeq:    equalOps = (cycle < flipCycle);
            kBne:    equalOps = $random(seed) & 1;
            default: equalOps = 1'b0;
        endcase
        rs2ValE = equalOps ? rs1ValE : ~rs1ValE;
        if (stallF) begin
            stalls++;
        end
        cycle++;
    endtask

    always @(posedge clk) begin : modelStep
        logic [1:0]                      kindF;
        logic [4:0]                      btbIdx;
        logic [frontEndPkg::ghrBits-1:0] phtIdxF;
        logic                            predF;
        logic                            exValid;
        logic                            actual;
        logic                            misExp;
        frontEndPkg::addr_t              target;
        frontEndPkg::addr_t              redirect;
        if (reset) begin
            refPc   = frontEndPkg::pcStart;
            decSlot = '0;
            exeSlot = '0;
            refGhr  = '0;
            landed  = 1'b0;
            for (int i = 0; i < phtSize; i++) begin
                refPht[i] = frontEndPkg::counterInit;
            end
            for (int i = 0; i < 32; i++) begin
                btbValid[i] = 1'b0;
            end
        end else begin
            // Fetch side prediction
            kindF   = kindMem[refPc[7:2]];
            btbIdx  = refPc[6:2];
            phtIdxF = refGhr ^ refPc[6:2];
            predF   = btbValid[btbIdx] && (btbTag[btbIdx] == refPc[31:7]) &&
                      (kindF == kJal || (kindF != kOther && refPht[phtIdxF] >= 2'd2));

            // Execute side outcome
            exValid  = (exeSlot.kind != kOther);
            actual   = (exeSlot.kind == kJal) ||
                       (exeSlot.kind == kBeq && rs1ValE == rs2ValE) ||
                       (exeSlot.kind == kBne && rs1ValE != rs2ValE);
            target   = exeSlot.pc + exeSlot.offset;
            misExp   = exValid && (actual != exeSlot.predTaken);
            redirect = actual ? target : exeSlot.pc + 32'd4;

            checkValue("pcF_o", pcF, refPc);
            checkValue("mispredict_o", mispredict, misExp);
            checkValue("resolve_o.valid", resolve.valid, exValid);
            if (exValid) begin
                checkValue("resolve_o.pc", resolve.pc, exeSlot.pc);
                checkValue("resolve_o.isBranch", resolve.isBranch,
                           exeSlot.kind == kBeq || exeSlot.kind == kBne);
                checkValue("resolve_o.taken", resolve.taken, actual);
                checkValue("resolve_o.target", resolve.target, target);
                checkValue("resolve_o.phtIdx", resolve.phtIdx, exeSlot.phtIdx);
                checkValue("redirectPc_o", redirectPc, redirect);
            end

            if (misExp) begin
                mispredicts++;
            end
            if (kindF == kJal && predF && !stallF) begin
                jalHits++;
            end
            if (exeSlot.kind == kBeq && exeSlot.predTaken && !actual) begin
                fallThroughs++;
            end

            // History clears on a mispredict, else shifts on a fetched branch
            if (misExp) begin
                refGhr = '0;
            end else if (!stallF && !landed && (kindF == kBeq || kindF == kBne)) begin
                refGhr = {refGhr[frontEndPkg::ghrBits-2:0], predF};
            end
            if (exValid && exeSlot.kind != kJal) begin
                if (actual) begin
                    refPht[exeSlot.phtIdx] = (refPht[exeSlot.phtIdx] == 2'b11) ?
                                             2'b11 : refPht[exeSlot.phtIdx] + 2'b01;
                end else begin
                    refPht[exeSlot.phtIdx] = (refPht[exeSlot.phtIdx] == 2'b00) ?
                                             2'b00 : refPht[exeSlot.phtIdx] - 2'b01;
                end
            end
            if (exValid && actual) begin
                btbValid[exeSlot.pc[6:2]]  = 1'b1;
                btbTag[exeSlot.pc[6:2]]    = exeSlot.pc[31:7];
                btbTarget[exeSlot.pc[6:2]] = target;
            end

            // Pipeline advance, oldest stage first
            exeSlot = (misExp || stallF) ? slot_t'('0) : decSlot;
            if (misExp) begin
                decSlot = '0;
                refPc   = redirect;
            end else if (!stallF) begin
                decSlot = '{kindF, refPc, offsetMem[refPc[7:2]], predF, phtIdxF};
                refPc   = predF ? btbTarget[btbIdx] : refPc + 32'd4;
            end
            landed = misExp;
        end
    end

    initial begin
        seed         = 32'hc51f_efa6;
        cycle        = 0;
        mispredicts  = 0;
        jalHits      = 0;
        fallThroughs = 0;
        stalls       = 0;
        stallF       = 1'b0;
        instrF       = 32'h0000_0013;
        rs1ValE      = '0;
        rs2ValE      = '0;
        for (int i = 0; i < 64; i++) begin
            placeInstr(i, kOther, 0);
        end
        // Straight line, cold beq over two flushed slots, then the jal and bne loop
        placeInstr(8, kBeq, 16);
        placeInstr(9, kJal, -36);
        placeInstr(12, kJal, 16);
        placeInstr(18, kBeq, 8);
        placeInstr(21, kBne, -20);
        placeInstr(22, kJal, -40);

        @(negedge reset);
        driveInputs();
        repeat (runCycles) begin
            @(negedge clk);
            driveInputs();
        end

        if (mispredicts == 0 || jalHits == 0 || fallThroughs == 0 || stalls == 0) begin
            $display("A scenario was never reached: mispredicts %0d, jal hits %0d, %s %0d",
                     mispredicts, jalHits, "fall-throughs", fallThroughs);
            stopWithFailure();
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

    // Watchdog
    initial begin
        #(limitCycles * clkPeriod);
        $display("Timeout: the run did not finish within %0d cycles", limitCycles);
        stopWithFailure();
    end

endmodule

`default_nettype wire

/* filelist.f */
design/frontEndPkg.sv
design/pcGenerator.sv
design/branchTargetBuffer.sv
design/gsharePredictor.sv
design/pipeStage.sv
design/branchResolver.sv
design/frontControl.sv
design/fetchFrontEnd.sv
verif/clockGen.sv
verif/fetchFrontEndTb.sv
